//--- verilog.f
+incdir+hw
hw/ex_pkg.sv
hw/operand_forward.sv
hw/ex_issue_reg.sv
hw/alu_exec.sv
hw/execute_stage.sv
+incdir+testbench
testbench/execute_stage_assert.sv
testbench/execute_stage_tb.sv

//--- Makefile
# Verilator build and run for the execute stage testbench

VERILATOR ?= verilator
TOP       ?= execute_stage_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert

BIN     := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := hw/ex_cfg.svh testbench/ex_ref_model.svh

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q '^TESTS PASSED$$'

clean:
	rm -rf $(BUILD_DIR)

//--- testbench/ex_ref_model.svh
`ifndef EX_REF_MODEL_SVH
`define EX_REF_MODEL_SVH

function automatic logic [`EX_XLEN-1:0] sext_imm(input logic [`EX_IMM_W-1:0] imm);
    return `EX_XLEN'($signed(imm));
endfunction

function automatic logic [`EX_XLEN-1:0] sext32(input logic [31:0] v);
    return `EX_XLEN'($signed(v));
endfunction

function automatic logic is_load_op(input ex_pkg::alu_op_e op);
    return op inside {ex_pkg::op_lb, ex_pkg::op_lh, ex_pkg::op_lw, ex_pkg::op_ld,
                      ex_pkg::op_lbu, ex_pkg::op_lhu, ex_pkg::op_lwu};
endfunction

function automatic logic is_store_op(input ex_pkg::alu_op_e op);
    return op inside {ex_pkg::op_sb, ex_pkg::op_sh, ex_pkg::op_sw, ex_pkg::op_sd};
endfunction

function automatic logic is_branch_op(input ex_pkg::alu_op_e op);
    return op inside {ex_pkg::op_beq, ex_pkg::op_bne, ex_pkg::op_blt,
                      ex_pkg::op_bge, ex_pkg::op_bltu, ex_pkg::op_bgeu};
endfunction

function automatic ex_pkg::ex_result_t exp_result(
    input ex_pkg::alu_op_e        op,
    input logic [`EX_REG_W-1:0]   rd,
    input logic [`EX_XLEN-1:0]    a,
    input logic [`EX_XLEN-1:0]    b,
    input logic [`EX_IMM_W-1:0]   imm,
    input logic [`EX_XLEN-1:0]    pc
);
    ex_pkg::ex_result_t  r;
    logic [`EX_XLEN-1:0] ix;
    logic [`EX_XLEN-1:0] v;
    logic signed [31:0]  w;
    ix = sext_imm(imm);
    v = a + ix;
    w = a[31:0];
    case (op)
        ex_pkg::op_jal, ex_pkg::op_jalr: v = pc + 64'd4;
        ex_pkg::op_lui:   v = ix << 12;
        ex_pkg::op_auipc: v = pc + (ix << 12);
        ex_pkg::op_add:   v = a + b;
        ex_pkg::op_sub:   v = a - b;
        ex_pkg::op_and:   v = a & b;
        ex_pkg::op_or:    v = a | b;
        ex_pkg::op_xor:   v = a ^ b;
        ex_pkg::op_sll:   v = a << b[5:0];
        ex_pkg::op_srl:   v = a >> b[5:0];
        ex_pkg::op_sra:   v = $signed(a) >>> b[5:0];
        ex_pkg::op_slt:   v = {63'b0, $signed(a) < $signed(b)};
        ex_pkg::op_sltu:  v = {63'b0, a < b};
        ex_pkg::op_andi:  v = a & ix;
        ex_pkg::op_ori:   v = a | ix;
        ex_pkg::op_xori:  v = a ^ ix;
        ex_pkg::op_slli:  v = a << imm[5:0];
        ex_pkg::op_srli:  v = a >> imm[5:0];
        ex_pkg::op_srai:  v = $signed(a) >>> imm[5:0];
        ex_pkg::op_slti:  v = {63'b0, $signed(a) < $signed(ix)};
        ex_pkg::op_sltiu: v = {63'b0, a < ix};
        ex_pkg::op_addw:  v = sext32(a[31:0] + b[31:0]);
        ex_pkg::op_subw:  v = sext32(a[31:0] - b[31:0]);
        ex_pkg::op_sllw:  v = sext32(a[31:0] << b[4:0]);
        ex_pkg::op_srlw:  v = sext32(a[31:0] >> b[4:0]);
        ex_pkg::op_sraw:  v = sext32(w >>> b[4:0]);
        ex_pkg::op_addiw: v = sext32(a[31:0] + ix[31:0]);
        ex_pkg::op_slliw: v = sext32(a[31:0] << imm[4:0]);
        ex_pkg::op_srliw: v = sext32(a[31:0] >> imm[4:0]);
        ex_pkg::op_sraiw: v = sext32(w >>> imm[4:0]);
        default: ;
    endcase
    r.rd = rd;
    r.value = v;
    r.store_data = b;
    r.wb_active = !is_store_op(op) && !is_branch_op(op) && (rd != '0);
    r.is_load = is_load_op(op);
    return r;
endfunction

function automatic ex_pkg::mem_ctl_t exp_mem_ctl(input ex_pkg::alu_op_e op);
    ex_pkg::mem_ctl_t m;
    m.active = is_load_op(op) || is_store_op(op);
    m.load = is_load_op(op);
    m.is_unsigned = op inside {ex_pkg::op_lbu, ex_pkg::op_lhu, ex_pkg::op_lwu};
    if (op inside {ex_pkg::op_lb, ex_pkg::op_lbu, ex_pkg::op_sb}) begin
        m.size = ex_pkg::size_byte;
    end else if (op inside {ex_pkg::op_lh, ex_pkg::op_lhu, ex_pkg::op_sh}) begin
        m.size = ex_pkg::size_half;
    end else if (op inside {ex_pkg::op_lw, ex_pkg::op_lwu, ex_pkg::op_sw}) begin
        m.size = ex_pkg::size_word;
    end else begin
        m.size = ex_pkg::size_double;
    end
    return m;
endfunction

function automatic ex_pkg::redirect_t exp_redirect(
    input ex_pkg::alu_op_e        op,
    input logic [`EX_XLEN-1:0]    a,
    input logic [`EX_XLEN-1:0]    b,
    input logic [`EX_IMM_W-1:0]   imm,
    input logic [`EX_XLEN-1:0]    pc
);
    ex_pkg::redirect_t r;
    r.target = pc + sext_imm(imm);
    case (op)
        ex_pkg::op_beq:  r.taken = (a == b);
        ex_pkg::op_bne:  r.taken = (a != b);
        ex_pkg::op_blt:  r.taken = $signed(a) < $signed(b);
        ex_pkg::op_bge:  r.taken = $signed(a) >= $signed(b);
        ex_pkg::op_bltu: r.taken = a < b;
        ex_pkg::op_bgeu: r.taken = a >= b;
        ex_pkg::op_jal:  r.taken = 1'b1;
        ex_pkg::op_jalr: begin
            r.taken = 1'b1;
            r.target = (a + sext_imm(imm)) & ~64'd1;
        end
        default:         r.taken = 1'b0;
    endcase
    return r;
endfunction

`endif

//--- testbench/execute_stage_tb.sv
`timescale 1ns/100ps
`include "ex_cfg.svh"

module execute_stage_tb;

    logic               clk;
    logic               reset;
    logic               in_valid;
    ex_pkg::ex_req_t    in_req;
    ex_pkg::fwd_src_t   mem_fwd;
    ex_pkg::fwd_src_t   wb_fwd;
    logic               mem_stall;
    logic               out_valid;
    ex_pkg::ex_result_t out_result;
    ex_pkg::mem_ctl_t   mem_ctl;
    ex_pkg::redirect_t  redirect;
    logic               stall;

    logic [15:0]         lfsr;
    logic [`EX_XLEN-1:0] regfile [0:4];
    logic [`EX_XLEN-1:0] gold [0:4];
    ex_pkg::ex_req_t     exp_q[$];
    ex_pkg::ex_req_t     cur_req;
    ex_pkg::ex_result_t  head_er;
    ex_pkg::fwd_src_t    mem_st;
    ex_pkg::fwd_src_t    wb_st;
    logic                have_req;
    logic                timed_out;
    string               cur_test;
    int                  issued;
    int                  flushed;
    int                  checks;
    int                  errors;

    `include "ex_ref_model.svh"

    execute_stage i_execute_stage (
        .clk        (clk),
        .reset      (reset),
        .in_valid   (in_valid),
        .in_req     (in_req),
        .mem_fwd    (mem_fwd),
        .wb_fwd     (wb_fwd),
        .mem_stall  (mem_stall),
        .out_valid  (out_valid),
        .out_result (out_result),
        .mem_ctl    (mem_ctl),
        .redirect   (redirect),
        .stall      (stall)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // galois lfsr stepped once per bit
    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
            v = {v[62:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic int rand_int(input int n);
        return int'(rand_bits(n));
    endfunction

    function automatic ex_pkg::alu_op_e pick_op(input int phase);
        int n;
        int sel;
        sel = rand_int(2);
        case (phase)
            0: n = (sel == 0) ? 19 + rand_int(1) : (sel == 1) ? 40 + rand_int(8) % 9
                                                              : 21 + rand_int(8) % 19;
            1: n = rand_int(8) % 11;
            2: n = (sel == 0) ? 40 + rand_int(8) % 9 : 21 + rand_int(8) % 19;
            3: n = (sel < 2) ? rand_int(8) % 7 : 21 + rand_int(8) % 19;
            4: n = (sel < 2) ? 11 + rand_int(8) % 8 : 21 + rand_int(8) % 19;
            default: n = rand_int(8) % 49;
        endcase
        return ex_pkg::alu_op_e'(n[5:0]);
    endfunction

    // small register pool keeps hazards frequent
    function automatic ex_pkg::ex_req_t make_req(input int phase);
        ex_pkg::ex_req_t r;
        logic [63:0]     pc_bits;
        r.op = pick_op(phase);
        r.rd = 5'(rand_int(8) % 5);
        r.rs1_addr = 5'(rand_int(8) % 5);
        r.rs2_addr = 5'(rand_int(8) % 5);
        r.rs1_val = regfile[r.rs1_addr];
        r.rs2_val = regfile[r.rs2_addr];
        r.imm = `EX_IMM_W'(rand_bits(`EX_IMM_W));
        pc_bits = rand_bits(30);
        r.pc = {32'b0, pc_bits[29:0], 2'b00};
        return r;
    endfunction

    task automatic check_result(input ex_pkg::ex_result_t exp_r, input ex_pkg::ex_result_t act,
                                input logic care_value, input logic care_store);
        logic bad;
        bad = (exp_r.rd != act.rd) || (exp_r.wb_active != act.wb_active)
            || (exp_r.is_load != act.is_load)
            || (care_value && exp_r.value != act.value)
            || (care_store && exp_r.store_data != act.store_data);
        checks++;
        if (bad) begin
            $display("[FAIL] %s result: expected %h, actual %h", cur_test, exp_r, act);
            errors++;
        end
    endtask

    task automatic check_mem_ctl(input ex_pkg::mem_ctl_t exp_m, input ex_pkg::mem_ctl_t act);
        logic bad;
        bad = (exp_m.active != act.active) || (exp_m.load != act.load)
            || (exp_m.active && (exp_m.size != act.size
                                 || exp_m.is_unsigned != act.is_unsigned));
        checks++;
        if (bad) begin
            $display("[FAIL] %s mem_ctl: expected %h, actual %h", cur_test, exp_m, act);
            errors++;
        end
    endtask

    task automatic check_redirect(input ex_pkg::redirect_t exp_d, input ex_pkg::redirect_t act);
        logic bad;
        bad = (exp_d.taken != act.taken) || (exp_d.taken && exp_d.target != act.target);
        checks++;
        if (bad) begin
            $display("[FAIL] %s redirect: expected %h, actual %h", cur_test, exp_d, act);
            errors++;
        end
    endtask

    task automatic check_stall(input logic exp_s, input logic act);
        checks++;
        if (exp_s != act) begin
            $display("[FAIL] %s stall: expected %b, actual %b", cur_test, exp_s, act);
            errors++;
        end
    endtask

    task automatic step_cycle(input int phase, input logic may_issue);
        ex_pkg::ex_req_t      h;
        ex_pkg::mem_ctl_t     em;
        ex_pkg::redirect_t    ed;
        ex_pkg::fwd_src_t     ms_next;
        logic [`EX_XLEN-1:0]  a;
        logic [`EX_XLEN-1:0]  b;
        logic [`EX_REG_W-1:0] load_rd;
        logic                 exp_flush;
        logic                 exp_stall;
        @(negedge clk);
        load_rd = '0;
        exp_flush = 1'b0;
        if (out_valid) begin
            if (exp_q.size() == 0) begin
                $display("%s: valid output with no instruction in flight", cur_test);
                errors++;
            end else begin
                h = exp_q[0];
                a = gold[h.rs1_addr];
                b = gold[h.rs2_addr];
                head_er = exp_result(h.op, h.rd, a, b, h.imm, h.pc);
                em = exp_mem_ctl(h.op);
                ed = exp_redirect(h.op, a, b, h.imm, h.pc);
                check_result(head_er, out_result, head_er.wb_active || em.active,
                             em.active && !em.load);
                check_mem_ctl(em, mem_ctl);
                check_redirect(ed, redirect);
                // a held load blocks its consumers for one cycle
                if (head_er.is_load) begin
                    load_rd = h.rd;
                end
                exp_flush = ed.taken;
            end
        end
        mem_stall = (phase == 5) && (rand_int(2) == 0);
        mem_fwd = mem_st;
        wb_fwd = wb_st;
        if (!have_req && may_issue) begin
            cur_req = make_req(phase);
            have_req = 1'b1;
        end
        in_valid = have_req;
        in_req = cur_req;
        #1;
        exp_stall = mem_stall || (in_valid && load_rd != '0
                    && (load_rd == in_req.rs1_addr || load_rd == in_req.rs2_addr));
        check_stall(exp_stall, stall);
        // memory and write-back model advance with execute
        if (!mem_stall) begin
            if (mem_st.wb_active) begin
                regfile[mem_st.rd] = mem_st.value;
            end
            wb_st = mem_st;
            ms_next = '0;
            if (out_valid && exp_q.size() > 0) begin
                h = exp_q.pop_front();
                ms_next.rd = h.rd;
                ms_next.wb_active = head_er.wb_active;
                ms_next.value = head_er.is_load ? rand_bits(64) : head_er.value;
                if (ms_next.wb_active) begin
                    gold[h.rd] = ms_next.value;
                end
            end
            mem_st = ms_next;
        end
        if (in_valid && !stall) begin
            if (exp_flush) begin
                flushed++;
            end else begin
                exp_q.push_back(cur_req);
                issued++;
            end
            have_req = 1'b0;
        end
    endtask

    task automatic run_test(input string name, input int phase, input int count);
        int cycles;
        int err0;
        int chk0;
        cur_test = name;
        issued = 0;
        cycles = 0;
        err0 = errors;
        chk0 = checks;
        while (issued < count || have_req || exp_q.size() != 0) begin
            step_cycle(phase, issued < count);
            cycles++;
            if (cycles > count * 20) begin
                $display("%s: timeout, instructions stopped retiring", name);
                timed_out = 1'b1;
                break;
            end
        end
        $display("test %s: %0d checks, %0d errors", name, checks - chk0, errors - err0);
    endtask

    initial begin
        reset = 1'b1;
        in_valid = 1'b0;
        in_req = '0;
        mem_fwd = '0;
        wb_fwd = '0;
        mem_stall = 1'b0;
        cur_req = '0;
        mem_st = '0;
        wb_st = '0;
        have_req = 1'b0;
        timed_out = 1'b0;
        lfsr = 16'd8364;
        flushed = 0;
        checks = 0;
        errors = 0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        regfile[0] = '0;
        gold[0] = '0;
        for (int i = 1; i < 5; i++) begin
            regfile[i] = rand_bits(64);
            gold[i] = regfile[i];
        end
        run_test("alu_w_forms", 0, 300);
        if (!timed_out) run_test("load_store", 1, 200);
        if (!timed_out) run_test("forwarding", 2, 300);
        if (!timed_out) run_test("load_use", 3, 300);
        if (!timed_out) run_test("branch_jump", 4, 300);
        if (!timed_out) run_test("mem_stall", 5, 400);
        $display("total: %0d checks, %0d errors, %0d flushed requests", checks, errors, flushed);
        if (errors == 0 && !timed_out) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- testbench/execute_stage_assert.sv
`timescale 1ns/100ps

module execute_stage_assert (
    input logic clk,
    input logic reset,
    input logic stall,
    input logic mem_stall,
    input logic out_valid,
    input logic redirect_taken,
    input logic mem_active
);

    // load-use costs a single bubble
    stall_one_cycle: assert property (@(posedge clk) disable iff (reset)
        (stall && !mem_stall) |=> (!stall || mem_stall))
        else $error("stall high for two cycles without mem_stall");

    // wrong-path request is dropped
    flush_bubble: assert property (@(posedge clk) disable iff (reset)
        (redirect_taken && !mem_stall) |=> !out_valid)
        else $error("valid output right after a taken redirect");

    outputs_need_valid: assert property (@(posedge clk) disable iff (reset)
        (mem_active || redirect_taken) |-> out_valid)
        else $error("memory request or redirect without out_valid");

endmodule

bind execute_stage execute_stage_assert i_execute_stage_assert (
    .clk            (clk),
    .reset          (reset),
    .stall          (stall),
    .mem_stall      (mem_stall),
    .out_valid      (out_valid),
    .redirect_taken (redirect.taken),
    .mem_active     (mem_ctl.active)
);

//--- hw/execute_stage.sv
`timescale 1ns/100ps
`include "ex_cfg.svh"

module execute_stage (
    input  logic                clk,
    input  logic                reset,
    input  logic                in_valid,
    input  ex_pkg::ex_req_t     in_req,
    input  ex_pkg::fwd_src_t    mem_fwd,
    input  ex_pkg::fwd_src_t    wb_fwd,
    input  logic                mem_stall,
    output logic                out_valid,
    output ex_pkg::ex_result_t  out_result,
    output ex_pkg::mem_ctl_t    mem_ctl,
    output ex_pkg::redirect_t   redirect,
    output logic                stall
);

    logic [`EX_XLEN-1:0] fwd_rs1_val;
    logic [`EX_XLEN-1:0] fwd_rs2_val;
    logic                load_use;
    ex_pkg::ex_req_t     held_req;

    // held result feeds back as the newest forwarding source
    operand_forward i_operand_forward (
        .in_valid  (in_valid),
        .in_req    (in_req),
        .ex_valid  (out_valid),
        .ex_result (out_result),
        .mem_fwd   (mem_fwd),
        .wb_fwd    (wb_fwd),
        .rs1_val   (fwd_rs1_val),
        .rs2_val   (fwd_rs2_val),
        .load_use  (load_use)
    );

    // a taken redirect turns the incoming request into a bubble
    ex_issue_reg i_ex_issue_reg (
        .clk        (clk),
        .reset      (reset),
        .mem_stall  (mem_stall),
        .load_use   (load_use),
        .in_valid   (in_valid),
        .in_req     (in_req),
        .rs1_val    (fwd_rs1_val),
        .rs2_val    (fwd_rs2_val),
        .flush      (redirect.taken),
        .held_req   (held_req),
        .held_valid (out_valid),
        .stall      (stall)
    );

    alu_exec i_alu_exec (
        .held_valid (out_valid),
        .held_req   (held_req),
        .result     (out_result),
        .mem_ctl    (mem_ctl),
        .redirect   (redirect)
    );

endmodule

//--- hw/alu_exec.sv
`timescale 1ns/100ps
`include "ex_cfg.svh"

module alu_exec (
    input  logic                held_valid,
    input  ex_pkg::ex_req_t     held_req,
    output ex_pkg::ex_result_t  result,
    output ex_pkg::mem_ctl_t    mem_ctl,
    output ex_pkg::redirect_t   redirect
);

    logic [`EX_XLEN-1:0] rs1;
    logic [`EX_XLEN-1:0] rs2;
    logic [`EX_XLEN-1:0] imm_x;
    logic [`EX_XLEN-1:0] upper_imm;
    logic [`EX_XLEN-1:0] addr;
    logic [`EX_XLEN-1:0] pc_plus4;
    logic [`EX_XLEN-1:0] alu_value;
    logic [`EX_XLEN-1:0] target;
    logic                lt_s;
    logic                lt_u;
    logic                lti_s;
    logic                lti_u;
    logic                wb;
    logic                is_load;
    logic                mem_access;
    logic                is_unsigned;
    logic                taken;
    ex_pkg::ls_size_e    size;

    function automatic logic [`EX_XLEN-1:0] sext_w(input logic [31:0] v);
        return {{(`EX_XLEN-32){v[31]}}, v};
    endfunction

    assign rs1 = held_req.rs1_val;
    assign rs2 = held_req.rs2_val;
    assign imm_x = {{(`EX_XLEN-`EX_IMM_W){held_req.imm[`EX_IMM_W-1]}}, held_req.imm};
    // lui value, sign extended from bit 31
    assign upper_imm = {{(`EX_XLEN-`EX_IMM_W-12){held_req.imm[`EX_IMM_W-1]}},
                        held_req.imm, 12'b0};
    assign addr = rs1 + imm_x;
    assign pc_plus4 = held_req.pc + 4;

    assign lt_s = $signed(rs1) < $signed(rs2);
    assign lt_u = rs1 < rs2;
    assign lti_s = $signed(rs1) < $signed(imm_x);
    assign lti_u = rs1 < imm_x;

    always_comb begin
        alu_value   = addr;
        wb          = 1'b1;
        is_load     = 1'b0;
        mem_access  = 1'b0;
        is_unsigned = 1'b0;
        size        = ex_pkg::size_double;
        taken       = 1'b0;
        target      = held_req.pc + imm_x;
        case (held_req.op)
            ex_pkg::op_lb, ex_pkg::op_lbu: begin
                is_load     = 1'b1;
                mem_access  = 1'b1;
                size        = ex_pkg::size_byte;
                is_unsigned = (held_req.op == ex_pkg::op_lbu);
            end
            ex_pkg::op_lh, ex_pkg::op_lhu: begin
                is_load     = 1'b1;
                mem_access  = 1'b1;
                size        = ex_pkg::size_half;
                is_unsigned = (held_req.op == ex_pkg::op_lhu);
            end
            ex_pkg::op_lw, ex_pkg::op_lwu: begin
                is_load     = 1'b1;
                mem_access  = 1'b1;
                size        = ex_pkg::size_word;
                is_unsigned = (held_req.op == ex_pkg::op_lwu);
            end
            ex_pkg::op_ld: begin
                is_load    = 1'b1;
                mem_access = 1'b1;
            end
            ex_pkg::op_sb, ex_pkg::op_sh, ex_pkg::op_sw, ex_pkg::op_sd: begin
                wb         = 1'b0;
                mem_access = 1'b1;
                size       = ex_pkg::ls_size_e'(held_req.op - ex_pkg::op_sb);
            end
            ex_pkg::op_beq:  begin wb = 1'b0; taken = (rs1 == rs2); end
            ex_pkg::op_bne:  begin wb = 1'b0; taken = (rs1 != rs2); end
            ex_pkg::op_blt:  begin wb = 1'b0; taken = lt_s; end
            ex_pkg::op_bge:  begin wb = 1'b0; taken = ~lt_s; end
            ex_pkg::op_bltu: begin wb = 1'b0; taken = lt_u; end
            ex_pkg::op_bgeu: begin wb = 1'b0; taken = ~lt_u; end
            ex_pkg::op_jal: begin
                alu_value = pc_plus4;
                taken     = 1'b1;
            end
            ex_pkg::op_jalr: begin
                alu_value = pc_plus4;
                taken     = 1'b1;
                target    = {addr[`EX_XLEN-1:1], 1'b0};
            end
            ex_pkg::op_lui:   alu_value = upper_imm;
            ex_pkg::op_auipc: alu_value = held_req.pc + upper_imm;
            ex_pkg::op_add:   alu_value = rs1 + rs2;
            ex_pkg::op_sub:   alu_value = rs1 - rs2;
            ex_pkg::op_and:   alu_value = rs1 & rs2;
            ex_pkg::op_or:    alu_value = rs1 | rs2;
            ex_pkg::op_xor:   alu_value = rs1 ^ rs2;
            ex_pkg::op_sll:   alu_value = rs1 << rs2[5:0];
            ex_pkg::op_srl:   alu_value = rs1 >> rs2[5:0];
            ex_pkg::op_sra:   alu_value = $signed(rs1) >>> rs2[5:0];
            ex_pkg::op_slt:   alu_value = {{(`EX_XLEN-1){1'b0}}, lt_s};
            ex_pkg::op_sltu:  alu_value = {{(`EX_XLEN-1){1'b0}}, lt_u};
            ex_pkg::op_addi:  alu_value = addr;
            ex_pkg::op_andi:  alu_value = rs1 & imm_x;
            ex_pkg::op_ori:   alu_value = rs1 | imm_x;
            ex_pkg::op_xori:  alu_value = rs1 ^ imm_x;
            ex_pkg::op_slli:  alu_value = rs1 << held_req.imm[5:0];
            ex_pkg::op_srli:  alu_value = rs1 >> held_req.imm[5:0];
            ex_pkg::op_srai:  alu_value = $signed(rs1) >>> held_req.imm[5:0];
            ex_pkg::op_slti:  alu_value = {{(`EX_XLEN-1){1'b0}}, lti_s};
            ex_pkg::op_sltiu: alu_value = {{(`EX_XLEN-1){1'b0}}, lti_u};
            // 32-bit forms, result sign extended from bit 31
            ex_pkg::op_addw:  alu_value = sext_w(rs1[31:0] + rs2[31:0]);
            ex_pkg::op_subw:  alu_value = sext_w(rs1[31:0] - rs2[31:0]);
            ex_pkg::op_sllw:  alu_value = sext_w(rs1[31:0] << rs2[4:0]);
            ex_pkg::op_srlw:  alu_value = sext_w(rs1[31:0] >> rs2[4:0]);
            ex_pkg::op_sraw:  alu_value = sext_w($signed(rs1[31:0]) >>> rs2[4:0]);
            ex_pkg::op_addiw: alu_value = sext_w(addr[31:0]);
            ex_pkg::op_slliw: alu_value = sext_w(rs1[31:0] << held_req.imm[4:0]);
            ex_pkg::op_srliw: alu_value = sext_w(rs1[31:0] >> held_req.imm[4:0]);
            ex_pkg::op_sraiw: alu_value = sext_w($signed(rs1[31:0]) >>> held_req.imm[4:0]);
            default:          wb = 1'b0;
        endcase
    end

    always_comb begin
        result.rd          = held_req.rd;
        result.value       = alu_value;
        result.store_data  = rs2;
        // x0 destination computes but never writes back
        result.wb_active   = held_valid & wb & (held_req.rd != '0);
        result.is_load     = held_valid & is_load;
        mem_ctl.active     = held_valid & mem_access;
        mem_ctl.load       = held_valid & is_load;
        mem_ctl.size       = size;
        mem_ctl.is_unsigned = is_unsigned;
        redirect.taken     = held_valid & taken;
        redirect.target    = target;
    end

endmodule

//--- hw/ex_issue_reg.sv
`timescale 1ns/100ps
`include "ex_cfg.svh"

module ex_issue_reg (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 mem_stall,
    input  logic                 load_use,
    input  logic                 in_valid,
    input  ex_pkg::ex_req_t      in_req,
    input  logic [`EX_XLEN-1:0]  rs1_val,
    input  logic [`EX_XLEN-1:0]  rs2_val,
    input  logic                 flush,
    output ex_pkg::ex_req_t      held_req,
    output logic                 held_valid,
    output logic                 stall
);

    ex_pkg::ex_req_t next_req;
    logic            take;

    assign stall = mem_stall | load_use;

    // bubble on hazard, on wrong-path fetch or with nothing offered
    assign take = in_valid & ~load_use & ~flush;

    // forwarded operands replace the register file reads
    always_comb begin
        next_req         = in_req;
        next_req.rs1_val = rs1_val;
        next_req.rs2_val = rs2_val;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            held_valid <= 1'b0;
        end else if (!mem_stall) begin
            held_valid <= take;
        end
    end

    // contents freeze while memory is busy
    always_ff @(posedge clk) begin
        if (!mem_stall) begin
            held_req <= next_req;
        end
    end

endmodule

//--- hw/operand_forward.sv
`timescale 1ns/100ps
`include "ex_cfg.svh"

module operand_forward (
    input  logic                 in_valid,
    input  ex_pkg::ex_req_t      in_req,
    input  logic                 ex_valid,
    input  ex_pkg::ex_result_t   ex_result,
    input  ex_pkg::fwd_src_t     mem_fwd,
    input  ex_pkg::fwd_src_t     wb_fwd,
    output logic [`EX_XLEN-1:0]  rs1_val,
    output logic [`EX_XLEN-1:0]  rs2_val,
    output logic                 load_use
);

    logic ex_fwd_ok;
    logic ex_load;
    logic rs1_match;
    logic rs2_match;

    // newest producer wins, x0 always reads the register value
    function automatic logic [`EX_XLEN-1:0] select_operand(
        input logic [`EX_REG_W-1:0] addr,
        input logic [`EX_XLEN-1:0]  reg_val,
        input logic                 ex_ok,
        input ex_pkg::ex_result_t   ex_res,
        input ex_pkg::fwd_src_t     mem_src,
        input ex_pkg::fwd_src_t     wb_src
    );
        logic [`EX_XLEN-1:0] val;
        val = reg_val;
        if (addr != '0) begin
            if (ex_ok && ex_res.rd == addr) begin
                val = ex_res.value;
            end else if (mem_src.wb_active && mem_src.rd == addr) begin
                val = mem_src.value;
            end else if (wb_src.wb_active && wb_src.rd == addr) begin
                val = wb_src.value;
            end
        end
        return val;
    endfunction

    // a load in execute has only its address, not its data
    assign ex_fwd_ok = ex_valid & ex_result.wb_active & ~ex_result.is_load;

    assign rs1_val = select_operand(in_req.rs1_addr, in_req.rs1_val, ex_fwd_ok,
                                    ex_result, mem_fwd, wb_fwd);
    assign rs2_val = select_operand(in_req.rs2_addr, in_req.rs2_val, ex_fwd_ok,
                                    ex_result, mem_fwd, wb_fwd);

    assign ex_load = ex_valid & ex_result.is_load & (ex_result.rd != '0);
    assign rs1_match = (ex_result.rd == in_req.rs1_addr);
    assign rs2_match = (ex_result.rd == in_req.rs2_addr);

    // data shows up on mem_fwd one cycle later
    assign load_use = in_valid & ex_load & (rs1_match | rs2_match);

endmodule

//--- hw/ex_pkg.sv
`include "ex_cfg.svh"

package ex_pkg;

    typedef enum logic [5:0] {
        op_lb, op_lh, op_lw, op_ld, op_lbu, op_lhu, op_lwu,
        op_sb, op_sh, op_sw, op_sd,
        op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu,
        op_jal, op_jalr, op_lui, op_auipc,
        op_add, op_sub, op_and, op_or, op_xor,
        op_sll, op_srl, op_sra, op_slt, op_sltu,
        op_addi, op_andi, op_ori, op_xori,
        op_slli, op_srli, op_srai, op_slti, op_sltiu,
        op_addw, op_subw, op_sllw, op_srlw, op_sraw,
        op_addiw, op_slliw, op_srliw, op_sraiw
    } alu_op_e;

    typedef enum logic [1:0] {
        size_byte,
        size_half,
        size_word,
        size_double
    } ls_size_e;

    typedef struct packed {
        alu_op_e               op;
        logic [`EX_REG_W-1:0]  rd;
        logic [`EX_REG_W-1:0]  rs1_addr;
        logic [`EX_REG_W-1:0]  rs2_addr;
        logic [`EX_XLEN-1:0]   rs1_val;
        logic [`EX_XLEN-1:0]   rs2_val;
        logic [`EX_IMM_W-1:0]  imm;
        logic [`EX_XLEN-1:0]   pc;
    } ex_req_t;

    // producer as seen from memory or write-back
    typedef struct packed {
        logic [`EX_REG_W-1:0]  rd;
        logic [`EX_XLEN-1:0]   value;
        logic                  wb_active;
    } fwd_src_t;

    typedef struct packed {
        logic [`EX_REG_W-1:0]  rd;
        logic [`EX_XLEN-1:0]   value;
        logic [`EX_XLEN-1:0]   store_data;
        logic                  wb_active;
        logic                  is_load;
    } ex_result_t;

    typedef struct packed {
        logic                  active;
        logic                  load;
        ls_size_e              size;
        logic                  is_unsigned;
    } mem_ctl_t;

    typedef struct packed {
        logic                  taken;
        logic [`EX_XLEN-1:0]   target;
    } redirect_t;

endpackage

//--- hw/ex_cfg.svh
`ifndef EX_CFG_SVH
`define EX_CFG_SVH

// integer datapath width
`define EX_XLEN 64

// register file address width
`define EX_REG_W 5

// signed immediate as delivered by decode
`define EX_IMM_W 20

`endif
